/* logic/tfifo_pkg.sv */
// shared sizes and vector types for the tagged 1-to-N FIFO with shared storage
`default_nettype none

package tfifo_pkg;

   // number of output channels fed from the one input stream
   localparam int NUM_CHAN     = 4;
   // width of every data word carried through the FIFO
   localparam int DATA_W       = 16;
   // words of shared RAM set aside for each channel
   localparam int ELS_PER_CHAN = 8;
   // depth of the little output FIFO in front of each consumer
   localparam int BUF_DEPTH    = 4;

   // the tag selects one channel
   localparam int TAG_W     = $clog2(NUM_CHAN);
   // pointer inside one channel's region of the shared RAM
   localparam int PTR_W     = $clog2(ELS_PER_CHAN);
   // shared RAM address is the tag on top of the region pointer
   localparam int ADDR_W    = TAG_W + PTR_W;
   // credit counters must reach BUF_DEPTH itself, so one extra value
   localparam int CNT_W     = $clog2(BUF_DEPTH + 1);
   // pointer inside one little output FIFO
   localparam int BUF_PTR_W = $clog2(BUF_DEPTH);

   // one payload word
   typedef logic [DATA_W-1:0]   data_t;
   // channel number as carried with each input word
   typedef logic [TAG_W-1:0]    tag_t;
   // read or write position inside a channel region
   typedef logic [PTR_W-1:0]    ptr_t;
   // full address into the shared RAM
   typedef logic [ADDR_W-1:0]   addr_t;
   // one bit per channel for requests, grants, valids and dequeues
   typedef logic [NUM_CHAN-1:0] chan_vec_t;

endpackage

`default_nettype wire

/* logic/chan_tracker.sv */
// per-channel region tracker with read and write pointers and little-FIFO credits
`timescale 1ns/100ps
`default_nettype none

module chan_tracker
(
   input  wire              clk_i,
   input  wire              rst_i,
   input  wire              enq_i,
   input  wire              deq_i,
   input  wire              credit_ret_i,
   output tfifo_pkg::ptr_t  wptr_o,
   output tfifo_pkg::ptr_t  rptr_o,
   output logic             full_o,
   output logic             empty_o,
   output logic             req_o
);

   import tfifo_pkg::*;

   // pointers wrap on their own since ELS_PER_CHAN is a power of two
   ptr_t             wptr_r;
   ptr_t             rptr_r;
   // occupancy runs from 0 up to ELS_PER_CHAN, so it needs one bit more than a pointer
   logic [PTR_W:0]   used_r;
   // free slots left in this channel's little output FIFO
   logic [CNT_W-1:0] credit_r;

   // enq_i is already gated by full_o at the top level
   // and deq_i only arrives as a grant on a live request
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wptr_r <= '0;
         rptr_r <= '0;
         used_r <= '0;
      end
      else
      begin
         if (enq_i)
            wptr_r <= wptr_r + 1'b1;
         if (deq_i)
            rptr_r <= rptr_r + 1'b1;
         // simultaneous push and pop leave the occupancy unchanged
         if (enq_i && !deq_i)
            used_r <= used_r + 1'b1;
         else if (!enq_i && deq_i)
            used_r <= used_r - 1'b1;
      end
   end

   // a RAM read spends a credit, a consumer dequeue returns one
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         credit_r <= CNT_W'(BUF_DEPTH);
      else if (deq_i && !credit_ret_i)
         credit_r <= credit_r - 1'b1;
      else if (!deq_i && credit_ret_i)
         credit_r <= credit_r + 1'b1;
   end

   assign wptr_o  = wptr_r;
   assign rptr_o  = rptr_r;
   // flags come straight from the registered occupancy
   assign full_o  = (used_r == (PTR_W+1)'(ELS_PER_CHAN));
   assign empty_o = (used_r == '0);
   // ask for a RAM read only when a word waits and the little FIFO has room
   assign req_o   = !empty_o && (credit_r != '0);

endmodule

`default_nettype wire

/* logic/rr_read_arbiter.sv */
// round-robin arbiter that picks which channel reads the shared RAM this cycle
`timescale 1ns/100ps
`default_nettype none

module rr_read_arbiter
(
   input  wire                   clk_i,
   input  wire                   rst_i,
   input  tfifo_pkg::chan_vec_t  req_i,
   output tfifo_pkg::chan_vec_t  grant_o,
   output tfifo_pkg::tag_t       grant_tag_o,
   output logic                  grant_v_o
);

   import tfifo_pkg::*;

   // channel that gets first look in the next scan
   tag_t prio_r;
   // channel number visited during the scan
   int   scan;

   // walk the channels starting at the priority pointer and stop at the first request
   always_comb
   begin
      grant_o     = '0;
      grant_tag_o = '0;
      grant_v_o   = 1'b0;
      scan        = 0;
      for (int i = 0; i < NUM_CHAN; i++)
      begin
         scan = int'(prio_r) + i;
         // wrap the scan back to channel zero
         if (scan >= NUM_CHAN)
            scan = scan - NUM_CHAN;
         if (!grant_v_o && req_i[scan])
         begin
            grant_v_o     = 1'b1;
            grant_o[scan] = 1'b1;
            grant_tag_o   = tag_t'(scan);
         end
      end
   end

   // the winner drops to lowest priority so nobody waits more than NUM_CHAN-1 grants
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         prio_r <= '0;
      else if (grant_v_o)
      begin
         if (grant_tag_o == tag_t'(NUM_CHAN - 1))
            prio_r <= '0;
         else
            prio_r <= grant_tag_o + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* logic/shared_ram.sv */
// two-port RAM holding every channel's region, with one write port and a registered read port
`timescale 1ns/100ps
`default_nettype none

module shared_ram
(
   input  wire               clk_i,
   input  wire               we_i,
   input  tfifo_pkg::addr_t  waddr_i,
   input  tfifo_pkg::data_t  wdata_i,
   input  wire               re_i,
   input  tfifo_pkg::addr_t  raddr_i,
   output tfifo_pkg::data_t  rdata_o
);

   import tfifo_pkg::*;

   // one region of ELS_PER_CHAN words per channel, selected by the tag bits
   data_t mem [NUM_CHAN*ELS_PER_CHAN];
   // read data stays put between reads
   data_t rdata_r;

   always_ff @(posedge clk_i)
   begin
      if (we_i)
         mem[waddr_i] <= wdata_i;
   end

   // a region is read only at its read pointer while it holds a word,
   // so a read never lands on the slot being written in the same cycle
   always_ff @(posedge clk_i)
   begin
      if (re_i)
         rdata_r <= mem[raddr_i];
   end

   assign rdata_o = rdata_r;

endmodule

`default_nettype wire

/* logic/little_fifo_bank.sv */
// bank of small output FIFOs, one per channel, filled from shared RAM reads
`timescale 1ns/100ps
`default_nettype none

module little_fifo_bank
(
   input  wire                                          clk_i,
   input  wire                                          rst_i,
   input  wire                                          wr_v_i,
   input  tfifo_pkg::tag_t                              wr_tag_i,
   input  tfifo_pkg::data_t                             wr_data_i,
   input  tfifo_pkg::chan_vec_t                         yumi_i,
   output tfifo_pkg::chan_vec_t                         valid_o,
   output tfifo_pkg::data_t [tfifo_pkg::NUM_CHAN-1:0]   data_o
);

   import tfifo_pkg::*;

   // each channel gets its own circular buffer with private pointers
   for (genvar c = 0; c < NUM_CHAN; c++)
   begin : g_chan
      data_t                mem_r [BUF_DEPTH];
      logic [BUF_PTR_W-1:0] wr_ptr_r;
      logic [BUF_PTR_W-1:0] rd_ptr_r;
      // entries held, 0 to BUF_DEPTH
      logic [CNT_W-1:0]     count_r;
      logic                 push;
      logic                 pop;

      // the registered RAM word only belongs here when its tag matches
      assign push = wr_v_i && (wr_tag_i == tag_t'(c));
      // consumers only pulse yumi while valid is high
      assign pop  = yumi_i[c];

      // an arriving RAM word goes into the slot under the write pointer
      always_ff @(posedge clk_i)
      begin
         if (push)
            mem_r[wr_ptr_r] <= wr_data_i;
      end

      // no full check on push since the credit counters reserve a slot per read
      always_ff @(posedge clk_i)
      begin
         if (rst_i)
         begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
         end
         else
         begin
            if (push)
               wr_ptr_r <= wr_ptr_r + 1'b1;
            if (pop)
               rd_ptr_r <= rd_ptr_r + 1'b1;
            if (push && !pop)
               count_r <= count_r + 1'b1;
            else if (!push && pop)
               count_r <= count_r - 1'b1;
         end
      end

      // head word goes out combinationally from the read pointer
      assign valid_o[c] = (count_r != '0);
      assign data_o[c]  = mem_r[rd_ptr_r];
   end

endmodule

`default_nettype wire

/* logic/tagged_fifo_shared.sv */
// tagged 1-to-N FIFO that stores all channels in one shared RAM with small output buffers
`timescale 1ns/100ps
`default_nettype none

module tagged_fifo_shared
(
   input  wire                                          clk_i,
   input  wire                                          rst_i,
   input  wire                                          valid_i,
   input  tfifo_pkg::tag_t                              tag_i,
   input  tfifo_pkg::data_t                             data_i,
   output logic                                         yumi_o,
   output tfifo_pkg::chan_vec_t                         valid_o,
   input  tfifo_pkg::chan_vec_t                         yumi_i,
   output tfifo_pkg::data_t [tfifo_pkg::NUM_CHAN-1:0]   data_o
);

   import tfifo_pkg::*;

   // per-channel tracker state
   ptr_t      wptr [NUM_CHAN];
   ptr_t      rptr [NUM_CHAN];
   chan_vec_t full;
   chan_vec_t req;
   chan_vec_t enq;

   // arbiter result for the current cycle
   chan_vec_t grant;
   tag_t      grant_tag;
   logic      grant_v;

   // shared RAM ports
   addr_t     waddr;
   addr_t     raddr;
   data_t     ram_rdata;

   // read valid and tag delayed to line up with the registered RAM output
   logic      rd_v_r;
   tag_t      rd_tag_r;

   // the input word is taken in the same cycle unless its channel region is full
   assign yumi_o = valid_i && !full[tag_i];

   // turn the tag into a one-hot enqueue for the matching tracker
   always_comb
   begin
      enq         = '0;
      enq[tag_i]  = yumi_o;
   end

   for (genvar c = 0; c < NUM_CHAN; c++)
   begin : g_trk
      // a grant spends a credit, a consumer dequeue gives it back
      chan_tracker u_trk
      (
         .clk_i        (clk_i),
         .rst_i        (rst_i),
         .enq_i        (enq[c]),
         .deq_i        (grant[c]),
         .credit_ret_i (yumi_i[c]),
         .wptr_o       (wptr[c]),
         .rptr_o       (rptr[c]),
         .full_o       (full[c]),
         .empty_o      (),
         .req_o        (req[c])
      );
   end

   // only channels with a stored word and a free little-FIFO slot compete
   rr_read_arbiter u_arb
   (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_i       (req),
      .grant_o     (grant),
      .grant_tag_o (grant_tag),
      .grant_v_o   (grant_v)
   );

   // the tag picks the region and the channel's own pointer picks the slot
   assign waddr = {tag_i, wptr[tag_i]};
   assign raddr = {grant_tag, rptr[grant_tag]};

   // write and read may share a cycle on the two-port RAM
   shared_ram u_ram
   (
      .clk_i   (clk_i),
      .we_i    (yumi_o),
      .waddr_i (waddr),
      .wdata_i (data_i),
      .re_i    (grant_v),
      .raddr_i (raddr),
      .rdata_o (ram_rdata)
   );

   // read valid and read tag follow the grant by one cycle
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         rd_v_r <= 1'b0;
      else
         rd_v_r <= grant_v;
   end

   always_ff @(posedge clk_i)
   begin
      rd_tag_r <= grant_tag;
   end

   // RAM output lands in the tagged little FIFO one cycle after the grant
   little_fifo_bank u_bank
   (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .wr_v_i    (rd_v_r),
      .wr_tag_i  (rd_tag_r),
      .wr_data_i (ram_rdata),
      .yumi_i    (yumi_i),
      .valid_o   (valid_o),
      .data_o    (data_o)
   );

endmodule

`default_nettype wire

/* test/tagged_fifo_properties.sv */
// concurrent checks on the shared-storage FIFO handshakes and little-FIFO occupancy
`timescale 1ns/100ps
`default_nettype none

module tagged_fifo_properties
(
   input  wire                   clk_i,
   input  wire                   rst_i,
   input  wire                   take_i,
   input  tfifo_pkg::tag_t       tag_i,
   input  tfifo_pkg::chan_vec_t  grant_i,
   input  wire                   buf_wr_v_i,
   input  tfifo_pkg::tag_t       buf_wr_tag_i,
   input  tfifo_pkg::chan_vec_t  deq_i,
   input  tfifo_pkg::chan_vec_t  out_valid_i
);

   import tfifo_pkg::*;

   // assertion failures seen so far in this run
   int fail_count = 0;

   // outputs come out of reset idle
   a_reset_idle: assert property (@(posedge clk_i) $fell(rst_i) |-> out_valid_i == '0)
      else
      begin
         $error("valid_o not idle right after reset");
         fail_count++;
      end

   for (genvar c = 0; c < NUM_CHAN; c++)
   begin : g_chk
      logic             take;
      logic [PTR_W:0]   held;
      logic             push;
      logic [CNT_W-1:0] occ;

      assign take = take_i && (tag_i == tag_t'(c));
      assign push = buf_wr_v_i && (buf_wr_tag_i == tag_t'(c));

      // words waiting in this channel's RAM region as counted from takes and grants
      always_ff @(posedge clk_i)
      begin
         if (rst_i)
            held <= '0;
         else if (take && !grant_i[c])
            held <= held + 1'b1;
         else if (!take && grant_i[c])
            held <= held - 1'b1;
      end

      // a word is only accepted for a channel whose RAM region has room
      a_take_not_full: assert property (@(posedge clk_i) disable iff (rst_i)
                                        take |-> held != (PTR_W+1)'(ELS_PER_CHAN))
         else
         begin
            $error("input word taken for full channel %0d", c);
            fail_count++;
         end

      // independent occupancy count of this little FIFO
      always_ff @(posedge clk_i)
      begin
         if (rst_i)
            occ <= '0;
         else if (push && !deq_i[c])
            occ <= occ + 1'b1;
         else if (!push && deq_i[c])
            occ <= occ - 1'b1;
      end

      a_no_overfill: assert property (@(posedge clk_i) disable iff (rst_i)
                                      push |-> occ != CNT_W'(BUF_DEPTH))
         else
         begin
            $error("little FIFO %0d written while full", c);
            fail_count++;
         end
   end

endmodule

bind tagged_fifo_shared tagged_fifo_properties u_props
(
   .clk_i        (clk_i),
   .rst_i        (rst_i),
   .take_i       (yumi_o),
   .tag_i        (tag_i),
   .grant_i      (grant),
   .buf_wr_v_i   (rd_v_r),
   .buf_wr_tag_i (rd_tag_r),
   .deq_i        (yumi_i),
   .out_valid_i  (valid_o)
);

`default_nettype wire

/* test/tb_tagged_fifo_shared.sv */
// testbench for the tagged shared-storage FIFO with random producer, random consumers and scoreboard
`timescale 1ns/100ps
`default_nettype none

module tb_tagged_fifo_shared;

   import tfifo_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 3;
   localparam int SEED         = 63;
   localparam int MIX_CYCLES   = 1500;
   localparam int STALL_CYCLES = 600;
   localparam int PROBE_CYCLES = 20;
   localparam int DRAIN_LIMIT  = 200;
   // longer than any path from RAM to valid_o, so a quiet stretch means empty
   localparam int IDLE_CYCLES  = 16;
   localparam int TEST_CYCLES  = RESET_CYCLES + 2 * MIX_CYCLES + STALL_CYCLES
                                 + PROBE_CYCLES + 2 * DRAIN_LIMIT;
   localparam int WATCHDOG_NS  = (TEST_CYCLES + 1000) * CLK_PERIOD;
   // a stalled channel absorbs its RAM region plus its little FIFO
   localparam int CAP          = ELS_PER_CHAN + BUF_DEPTH;
   localparam tag_t STALL_CH   = tag_t'(3);
   // producer behaviour
   localparam int MODE_OFF     = 0;
   localparam int MODE_MIX     = 1;
   localparam int MODE_STALL   = 2;
   localparam int MODE_PROBE   = 3;

   logic                       clk_i;
   logic                       rst_i;
   logic                       valid_i;
   tag_t                       tag_i;
   data_t                      data_i;
   logic                       yumi_o;
   chan_vec_t                  valid_o;
   chan_vec_t                  yumi_i;
   data_t [NUM_CHAN-1:0]       data_o;

   // values for the next rising edge, chosen while the current cycle is stable
   logic                       nxt_valid;
   tag_t                       nxt_tag;
   data_t                      nxt_data;
   chan_vec_t                  yumi_plan;
   chan_vec_t                  cons_en;
   int                         rate [NUM_CHAN];
   int                         prod_mode;
   // words expected on each channel in arrival order
   data_t                      exp_q [NUM_CHAN][$];
   int                         errors;
   int                         taken3;
   int                         taken_low;
   int                         delivered_low;
   int                         refused;

   tagged_fifo_shared dut
   (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (valid_i),
      .tag_i   (tag_i),
      .data_i  (data_i),
      .yumi_o  (yumi_o),
      .valid_o (valid_o),
      .yumi_i  (yumi_i),
      .data_o  (data_o)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   task automatic note_error(string msg);
      $display("%s", msg);
      errors++;
   endtask

   // while channel 3 is stalled it only gets words until its capacity is used
   function automatic tag_t pick_tag();
      tag_t t;
      if (prod_mode == MODE_PROBE)
         t = STALL_CH;
      else if (prod_mode == MODE_STALL && taken3 >= CAP)
         t = tag_t'($urandom_range(2));
      else
         t = tag_t'($urandom_range(NUM_CHAN - 1));
      return t;
   endfunction

   // all inputs change only here, on the rising edge
   always @(posedge clk_i)
   begin
      valid_i <= nxt_valid;
      tag_i   <= nxt_tag;
      data_i  <= nxt_data;
      yumi_i  <= yumi_plan;
   end

   // scoreboard and checks run mid-cycle, then the next cycle is planned
   always @(negedge clk_i)
   begin
      data_t exp_word;
      if (!rst_i)
      begin
         if (valid_i && yumi_o)
         begin
            exp_q[tag_i].push_back(data_i);
            if (tag_i == STALL_CH)
               taken3++;
            else
               taken_low++;
         end
         if (prod_mode == MODE_PROBE && valid_i && tag_i == STALL_CH)
         begin
            assert (!yumi_o) else
               note_error($sformatf("Fail at %0d ns: yumi_o expected 0 actual 1", $time));
            refused++;
         end
         for (int c = 0; c < NUM_CHAN; c++)
         begin
            assert (!valid_o[c] || exp_q[c].size() != 0) else
               note_error($sformatf("Channel %0d offers a word that was never sent", c));
            if (yumi_i[c] && exp_q[c].size() != 0)
            begin
               exp_word = exp_q[c].pop_front();
               assert (data_o[c] == exp_word) else
                  note_error($sformatf("Fail at %0d ns: data_o[%0d] expected %h actual %h",
                                       $time, c, exp_word, data_o[c]));
               if (c != int'(STALL_CH))
                  delivered_low++;
            end
         end
      end
      // a refused word is held until it is taken
      if (!valid_i || yumi_o)
      begin
         nxt_valid = (prod_mode == MODE_PROBE) ||
                     (prod_mode != MODE_OFF && $urandom_range(99) < 70);
         nxt_tag   = pick_tag();
         nxt_data  = data_t'($urandom());
      end
      // a pulse never follows a pulse, so valid_o is still high at the next edge
      for (int c = 0; c < NUM_CHAN; c++)
         yumi_plan[c] = valid_o[c] && !yumi_i[c] && cons_en[c] &&
                        ($urandom_range(99) < rate[c]);
   end

   task automatic wait_for_idle();
      int quiet;
      int waited;
      quiet  = 0;
      waited = 0;
      while (quiet < IDLE_CYCLES && waited < DRAIN_LIMIT)
      begin
         @(negedge clk_i);
         waited++;
         if (!valid_i && valid_o == '0)
            quiet++;
         else
            quiet = 0;
      end
      assert (quiet >= IDLE_CYCLES) else
         note_error($sformatf("Outputs did not go idle within %0d cycles", DRAIN_LIMIT));
   endtask

   task automatic check_queues_empty();
      for (int c = 0; c < NUM_CHAN; c++)
         assert (exp_q[c].size() == 0) else
            note_error($sformatf("Channel %0d lost %0d words", c, exp_q[c].size()));
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns before the test finished", WATCHDOG_NS);
      $display("Verification failed");
      $finish;
   end

   initial
   begin
      void'($urandom(SEED));
      clk_i     = 1'b0;
      rst_i     = 1'b1;
      valid_i   = 1'b0;
      tag_i     = '0;
      data_i    = '0;
      yumi_i    = '0;
      nxt_valid = 1'b0;
      nxt_tag   = '0;
      nxt_data  = '0;
      yumi_plan = '0;
      cons_en   = '1;
      prod_mode = MODE_OFF;
      errors    = 0;
      taken3    = 0;
      refused   = 0;
      for (int c = 0; c < NUM_CHAN; c++)
         rate[c] = 30 + $urandom_range(59);
      repeat (RESET_CYCLES) @(posedge clk_i);
      rst_i <= 1'b0;
      @(negedge clk_i);
      assert (valid_o == '0) else
         note_error($sformatf("Fail at %0d ns: valid_o expected 0 actual %b", $time, valid_o));
      @(posedge clk_i);
      prod_mode = MODE_MIX;
      // every channel is empty, so the very first offer must be taken at once
      @(negedge clk_i);
      while (!valid_i)
         @(negedge clk_i);
      assert (yumi_o) else
         note_error($sformatf("Fail at %0d ns: yumi_o expected 1 actual 0", $time));
      repeat (MIX_CYCLES) @(posedge clk_i);
      prod_mode = MODE_OFF;
      wait_for_idle();
      check_queues_empty();
      // channel 3 consumer stops while the others keep running
      @(posedge clk_i);
      cons_en[STALL_CH] = 1'b0;
      taken3        = 0;
      taken_low     = 0;
      delivered_low = 0;
      prod_mode     = MODE_STALL;
      repeat (STALL_CYCLES) @(posedge clk_i);
      assert (taken3 == CAP) else
         note_error($sformatf("Fail at %0d ns: tag 3 words taken expected %0d actual %0d",
                              $time, CAP, taken3));
      assert (taken_low > 0 && delivered_low > 0) else
         note_error("Channels 0 to 2 made no progress while channel 3 was stalled");
      prod_mode = MODE_PROBE;
      repeat (PROBE_CYCLES) @(posedge clk_i);
      assert (refused > 0) else
         note_error("No word for the stalled channel 3 was offered to the DUT");
      cons_en[STALL_CH] = 1'b1;
      prod_mode = MODE_MIX;
      repeat (MIX_CYCLES) @(posedge clk_i);
      prod_mode = MODE_OFF;
      wait_for_idle();
      check_queues_empty();
      $display("Errors: %0d testbench checks, %0d property failures",
               errors, dut.u_props.fail_count);
      if (errors == 0 && dut.u_props.fail_count == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
logic/tfifo_pkg.sv
logic/chan_tracker.sv
logic/rr_read_arbiter.sv
logic/shared_ram.sv
logic/little_fifo_bank.sv
logic/tagged_fifo_shared.sv
test/tagged_fifo_properties.sv
test/tb_tagged_fifo_shared.sv

/* run.sh */
#!/bin/sh
# compile and run the tagged FIFO testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
   --top-module tb_tagged_fifo_shared -o tb_sim
if [ $? -ne 0 ]; then
   echo "compile step failed"
   exit 1
fi

./obj_dir/tb_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation returned status $status"
   exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
   exit 0
fi
exit 1
